//--- ta_pkg.sv
package ta_pkg;

    typedef struct packed {
        logic [7:0] d;
        logic       en;
        logic       er;
    } gmii_t;

    // bit 1 freeze, bit 0 run
    typedef struct packed {
        logic freeze;
        logic run;
    } ctrl_t;

    typedef logic [31:0] stat_t;

    typedef struct packed {
        logic  preamble_ok;
        logic  crc_ok;
        stat_t frame_octets;
        stat_t l2_octets;
    } frame_verdict_t;

    typedef enum logic [1:0] {
        FRAME_GOOD,
        FRAME_BAD_CRC,
        FRAME_BAD_PREAMBLE
    } frame_class_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FRAME,
        ST_CLOSE
    } rx_state_e;

    typedef struct packed {
        stat_t pkts, octets;
        stat_t bad_crc_pkts, bad_crc_octets;
        stat_t bad_preamble_pkts, bad_preamble_octets;
        stat_t octets_idle, octets_total;
    } stats_t;

    typedef struct packed {
        logic [11:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [11:0] araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_resp_t;

    localparam logic [11:0] REG_ID                  = 12'h000;
    localparam logic [11:0] REG_CONTROL             = 12'h004;
    localparam logic [11:0] REG_PKTS                = 12'h008;
    localparam logic [11:0] REG_OCTETS              = 12'h00C;
    localparam logic [11:0] REG_BAD_CRC_PKTS        = 12'h010;
    localparam logic [11:0] REG_BAD_CRC_OCTETS      = 12'h014;
    localparam logic [11:0] REG_BAD_PREAMBLE_PKTS   = 12'h018;
    localparam logic [11:0] REG_BAD_PREAMBLE_OCTETS = 12'h01C;
    localparam logic [11:0] REG_OCTETS_IDLE         = 12'h020;
    localparam logic [11:0] REG_OCTETS_TOTAL        = 12'h024;

    localparam logic [31:0] ID_VALUE = 32'h7A11_0001;

    localparam logic [7:0] PREAMBLE_OCTET = 8'h55;
    localparam logic [7:0] SFD_OCTET      = 8'hD5;

    // reflected ethernet crc-32
    localparam logic [31:0] CRC_POLY    = 32'hEDB8_8320;
    localparam logic [31:0] CRC_INIT    = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_RESIDUE = 32'hDEBB_20E3;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- frame_checker.sv
`timescale 1ns/1ps

module frame_checker import ta_pkg::*; (
    input  logic           clk,
    input  logic           resetn,
    input  gmii_t          gmii,
    input  logic           frame_start,
    input  logic           frame_active,
    output frame_verdict_t verdict
);

    stat_t       frame_octets;
    stat_t       l2_octets;
    logic        pre_ok;
    logic        er_seen;
    logic [31:0] crc;

    // one octet through the reflected crc, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        r = c ^ {24'd0, d};
        for (int i = 0; i < 8; i++) begin
            r = r[0] ? ((r >> 1) ^ CRC_POLY) : (r >> 1);
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pre_ok  <= 1'b0;
            er_seen <= 1'b0;
        end else if (frame_start) begin
            pre_ok  <= (gmii.d == PREAMBLE_OCTET);
            er_seen <= gmii.er;
        end else if (frame_active && gmii.en) begin
            // frame_octets is the index of the current octet here
            if (frame_octets < 32'd7) begin
                pre_ok <= pre_ok && (gmii.d == PREAMBLE_OCTET);
            end else if (frame_octets == 32'd7) begin
                pre_ok <= pre_ok && (gmii.d == SFD_OCTET);
            end
            er_seen <= er_seen || gmii.er;
        end
    end

    // counts and crc restart on every frame
    always_ff @(posedge clk) begin
        if (frame_start) begin
            frame_octets <= 32'd1;
            l2_octets    <= '0;
            crc          <= CRC_INIT;
        end else if (frame_active && gmii.en) begin
            frame_octets <= frame_octets + 32'd1;
            if (frame_octets >= 32'd8) begin
                l2_octets <= l2_octets + 32'd1;
                crc       <= crc_byte(crc, gmii.d);
            end
        end
    end

    // a frame cut short inside the preamble counts as bad preamble
    assign verdict.preamble_ok  = pre_ok && (frame_octets >= 32'd8);
    assign verdict.crc_ok       = (crc == CRC_RESIDUE) && !er_seen;
    assign verdict.frame_octets = frame_octets;
    assign verdict.l2_octets    = l2_octets;

    // close cycle would miss a new frame, so the gap is at least 2
    property p_min_gap;
        @(posedge clk) disable iff (!resetn)
        (frame_active && !gmii.en) |=> !gmii.en;
    endproperty

    a_min_gap: assert property (p_min_gap)
        else $error("frame_checker: inter-frame gap shorter than 2 cycles");

endmodule

//--- frame_rx_fsm.sv
`timescale 1ns/1ps

module frame_rx_fsm import ta_pkg::*; (
    input  logic           clk,
    input  logic           resetn,
    input  logic           gmii_en,
    input  ctrl_t          ctrl,
    input  frame_verdict_t verdict,
    output logic           frame_start,
    output logic           frame_active,
    output logic           commit,
    output frame_class_e   frame_class,
    output logic           publish
);

    rx_state_e state;
    logic      freeze_latched;

    assign frame_start  = (state == ST_IDLE) && gmii_en && ctrl.run;
    assign frame_active = (state == ST_FRAME);
    assign commit       = (state == ST_CLOSE);
    assign publish      = !freeze_latched;

    always_ff @(posedge clk) begin
        if (!resetn || !ctrl.run) begin
            state          <= ST_IDLE;
            freeze_latched <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (gmii_en) begin
                        state          <= ST_FRAME;
                        freeze_latched <= ctrl.freeze;
                    end
                end
                ST_FRAME: begin
                    if (!gmii_en) begin
                        state <= ST_CLOSE;
                    end
                end
                ST_CLOSE: state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // preamble errors win over crc errors
    always_comb begin
        if (!verdict.preamble_ok) begin
            frame_class = FRAME_BAD_PREAMBLE;
        end else if (!verdict.crc_ok) begin
            frame_class = FRAME_BAD_CRC;
        end else begin
            frame_class = FRAME_GOOD;
        end
    end

    property p_commit_pulse;
        @(posedge clk) disable iff (!resetn)
        commit |=> !commit;
    endproperty

    a_commit_pulse: assert property (p_commit_pulse)
        else $error("frame_rx_fsm: commit held for two cycles");

endmodule

//--- stats_counters.sv
`timescale 1ns/1ps

module stats_counters import ta_pkg::*; (
    input  logic           clk,
    input  logic           resetn,
    input  ctrl_t          ctrl,
    input  logic           gmii_en,
    input  logic           commit,
    input  frame_class_e   frame_class,
    input  logic           publish,
    input  frame_verdict_t verdict,
    output stats_t         snapshot
);

    stats_t live;
    stats_t live_next;

    always_comb begin
        live_next              = live;
        live_next.octets_total = live.octets_total + 32'd1;
        if (!gmii_en) begin
            live_next.octets_idle = live.octets_idle + 32'd1;
        end
        if (commit) begin
            case (frame_class)
                FRAME_GOOD: begin
                    live_next.pkts   = live.pkts + 32'd1;
                    live_next.octets = live.octets + verdict.l2_octets;
                end
                FRAME_BAD_CRC: begin
                    live_next.bad_crc_pkts   = live.bad_crc_pkts + 32'd1;
                    live_next.bad_crc_octets = live.bad_crc_octets + verdict.l2_octets;
                end
                FRAME_BAD_PREAMBLE: begin
                    live_next.bad_preamble_pkts = live.bad_preamble_pkts + 32'd1;
                    // whole frame, preamble included
                    live_next.bad_preamble_octets =
                        live.bad_preamble_octets + verdict.frame_octets;
                end
                default: begin
                    live_next.pkts = live.pkts;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || !ctrl.run) begin
            live     <= '0;
            snapshot <= '0;
        end else begin
            live <= live_next;

            // frame counters follow the freeze state seen at frame start
            if (commit && publish) begin
                snapshot.pkts                <= live_next.pkts;
                snapshot.octets              <= live_next.octets;
                snapshot.bad_crc_pkts        <= live_next.bad_crc_pkts;
                snapshot.bad_crc_octets      <= live_next.bad_crc_octets;
                snapshot.bad_preamble_pkts   <= live_next.bad_preamble_pkts;
                snapshot.bad_preamble_octets <= live_next.bad_preamble_octets;
            end

            // time counters track freeze directly
            if (!ctrl.freeze) begin
                snapshot.octets_idle  <= live.octets_idle;
                snapshot.octets_total <= live.octets_total;
            end
        end
    end

endmodule

//--- axil_regs.sv
`timescale 1ns/1ps

module axil_regs import ta_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  axil_req_t  axil_req,
    output axil_resp_t axil_resp,
    input  stats_t     snapshot,
    output ctrl_t      ctrl
);

    logic        wr_ready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        rd_ready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic [31:0] rd_data;
    logic [1:0]  rd_resp;

    // write channel, aw and w accepted together
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
            ctrl     <= '0;
        end else begin
            wr_ready <= axil_req.awvalid && axil_req.wvalid && !bvalid && !wr_ready;
            if (wr_ready) begin
                bvalid <= 1'b1;
                if (axil_req.awaddr == REG_CONTROL && axil_req.wstrb[0]) begin
                    ctrl <= ctrl_t'(axil_req.wdata[1:0]);
                end
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ready) begin
            bresp <= (axil_req.awaddr == REG_CONTROL) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_comb begin
        rd_resp = RESP_OKAY;
        case (axil_req.araddr)
            REG_ID:                  rd_data = ID_VALUE;
            REG_CONTROL:             rd_data = {30'd0, ctrl};
            REG_PKTS:                rd_data = snapshot.pkts;
            REG_OCTETS:              rd_data = snapshot.octets;
            REG_BAD_CRC_PKTS:        rd_data = snapshot.bad_crc_pkts;
            REG_BAD_CRC_OCTETS:      rd_data = snapshot.bad_crc_octets;
            REG_BAD_PREAMBLE_PKTS:   rd_data = snapshot.bad_preamble_pkts;
            REG_BAD_PREAMBLE_OCTETS: rd_data = snapshot.bad_preamble_octets;
            REG_OCTETS_IDLE:         rd_data = snapshot.octets_idle;
            REG_OCTETS_TOTAL:        rd_data = snapshot.octets_total;
            default: begin
                rd_data = '0;
                rd_resp = RESP_SLVERR;
            end
        endcase
    end

    // read channel
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_ready <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            rd_ready <= axil_req.arvalid && !rvalid && !rd_ready;
            if (rd_ready) begin
                rvalid <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_ready) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

    assign axil_resp.awready = wr_ready;
    assign axil_resp.wready  = wr_ready;
    assign axil_resp.bresp   = bresp;
    assign axil_resp.bvalid  = bvalid;
    assign axil_resp.arready = rd_ready;
    assign axil_resp.rdata   = rdata;
    assign axil_resp.rresp   = rresp;
    assign axil_resp.rvalid  = rvalid;

    property p_hold(valid, ready);
        @(posedge clk) disable iff (!resetn)
        (valid && !ready) |=> valid;
    endproperty

    a_bvalid_hold: assert property (p_hold(bvalid, axil_req.bready))
        else $error("axil_regs: bvalid dropped before bready");
    a_rvalid_hold: assert property (p_hold(rvalid, axil_req.rready))
        else $error("axil_regs: rvalid dropped before rready");

endmodule

//--- traffic_analyzer.sv
`timescale 1ns/1ps

module traffic_analyzer import ta_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  gmii_t      gmii,
    input  axil_req_t  axil_req,
    output axil_resp_t axil_resp
);

    ctrl_t          ctrl;
    logic           frame_start;
    logic           frame_active;
    frame_verdict_t verdict;
    logic           commit;
    frame_class_e   frame_class;
    logic           publish;
    stats_t         snapshot;

    frame_checker u_checker (
        .clk          (clk),
        .resetn       (resetn),
        .gmii         (gmii),
        .frame_start  (frame_start),
        .frame_active (frame_active),
        .verdict      (verdict)
    );

    frame_rx_fsm u_fsm (
        .clk          (clk),
        .resetn       (resetn),
        .gmii_en      (gmii.en),
        .ctrl         (ctrl),
        .verdict      (verdict),
        .frame_start  (frame_start),
        .frame_active (frame_active),
        .commit       (commit),
        .frame_class  (frame_class),
        .publish      (publish)
    );

    stats_counters u_stats (
        .clk         (clk),
        .resetn      (resetn),
        .ctrl        (ctrl),
        .gmii_en     (gmii.en),
        .commit      (commit),
        .frame_class (frame_class),
        .publish     (publish),
        .verdict     (verdict),
        .snapshot    (snapshot)
    );

    axil_regs u_regs (
        .clk       (clk),
        .resetn    (resetn),
        .axil_req  (axil_req),
        .axil_resp (axil_resp),
        .snapshot  (snapshot),
        .ctrl      (ctrl)
    );

endmodule

//--- tb_traffic_analyzer.sv
`timescale 1ns/1ps

module tb_traffic_analyzer import ta_pkg::*; ();

    typedef logic [7:0] octet_q_t[$];

    logic       clk;
    logic       resetn;
    gmii_t      gmii;
    axil_req_t  axil_req;
    axil_resp_t axil_resp;

    octet_q_t frame_q;
    int       frame_er_at;
    stats_t   expected;
    stat_t    en_cycles;

    traffic_analyzer dut (
        .clk       (clk),
        .resetn    (resetn),
        .gmii      (gmii),
        .axil_req  (axil_req),
        .axil_resp (axil_resp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_stat(input string name, input stat_t got, input stat_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t ns: %s is 0x%08h, expected 0x%08h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t ns: %s response is %0d, expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    function automatic string reg_name(input logic [11:0] addr);
        case (addr)
            REG_ID:                  return "id";
            REG_CONTROL:             return "control";
            REG_PKTS:                return "pkts";
            REG_OCTETS:              return "octets";
            REG_BAD_CRC_PKTS:        return "bad_crc_pkts";
            REG_BAD_CRC_OCTETS:      return "bad_crc_octets";
            REG_BAD_PREAMBLE_PKTS:   return "bad_preamble_pkts";
            REG_BAD_PREAMBLE_OCTETS: return "bad_preamble_octets";
            REG_OCTETS_IDLE:         return "octets_idle";
            REG_OCTETS_TOTAL:        return "octets_total";
            default:                 return "unmapped";
        endcase
    endfunction

    // bit-serial crc, lsb of each octet first
    function automatic logic [31:0] crc32_update(input logic [31:0] crc, input logic [7:0] octet);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int b = 0; b < 8; b++) begin
            fb = c[0] ^ octet[b];
            c  = {1'b0, c[31:1]};
            if (fb) begin
                c = c ^ CRC_POLY;
            end
        end
        return c;
    endfunction

    // expected counters after one frame seen with run set
    function automatic stats_t predict_stats(input stats_t s, input octet_q_t octets,
                                             input bit er_flag);
        stats_t      r;
        bit          pre_good;
        logic [31:0] crc;
        stat_t       l2;
        r        = s;
        pre_good = (octets.size() >= 8);
        for (int i = 0; i < 8 && i < octets.size(); i++) begin
            if (octets[i] != ((i == 7) ? SFD_OCTET : PREAMBLE_OCTET)) begin
                pre_good = 1'b0;
            end
        end
        crc = CRC_INIT;
        l2  = '0;
        for (int i = 8; i < octets.size(); i++) begin
            crc = crc32_update(crc, octets[i]);
            l2  = l2 + 32'd1;
        end
        if (!pre_good) begin
            r.bad_preamble_pkts   = r.bad_preamble_pkts + 32'd1;
            r.bad_preamble_octets = r.bad_preamble_octets + stat_t'(octets.size());
        end else if (crc != CRC_RESIDUE || er_flag) begin
            r.bad_crc_pkts   = r.bad_crc_pkts + 32'd1;
            r.bad_crc_octets = r.bad_crc_octets + l2;
        end else begin
            r.pkts   = r.pkts + 32'd1;
            r.octets = r.octets + l2;
        end
        return r;
    endfunction

    // kind 0 good, 1 bad preamble octet, 2 bad payload octet, 3 er pulse
    task automatic build_frame(input int kind);
        int unsigned len;
        int unsigned pos;
        logic [31:0] crc;
        logic [7:0]  octet;
        frame_q.delete();
        frame_er_at = -1;
        for (int i = 0; i < 7; i++) begin
            frame_q.push_back(PREAMBLE_OCTET);
        end
        frame_q.push_back(SFD_OCTET);
        len = 60 + ($urandom % 141);
        crc = CRC_INIT;
        for (int unsigned i = 0; i < len; i++) begin
            octet = 8'($urandom);
            frame_q.push_back(octet);
            crc = crc32_update(crc, octet);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            frame_q.push_back(crc[8 * i +: 8]);
        end
        if (kind == 1 || kind == 2) begin
            pos = (kind == 1) ? ($urandom % 8) : (8 + ($urandom % len));
            frame_q[pos] = frame_q[pos] ^ 8'(1 << ($urandom % 8));
        end else if (kind == 3) begin
            frame_er_at = int'($urandom % frame_q.size());
        end
    endtask

    task automatic send_frame();
        for (int i = 0; i < frame_q.size(); i++) begin
            @(negedge clk);
            gmii.d    = frame_q[i];
            gmii.en   = 1'b1;
            gmii.er   = (i == frame_er_at);
            en_cycles = en_cycles + 32'd1;
        end
        @(negedge clk);
        gmii = '0;
        repeat (11) @(negedge clk);
    endtask

    task automatic send_frames(input int count, input bit model);
        for (int i = 0; i < count; i++) begin
            build_frame(i % 4);
            if (model) begin
                expected = predict_stats(expected, frame_q, frame_er_at >= 0);
            end
            send_frame();
        end
    endtask

    task automatic tick_wait(inout int unsigned waited, input string what);
        @(negedge clk);
        waited++;
        if (waited > 100) begin
            report_failure({"timeout while waiting for ", what});
        end
    endtask

    task automatic write_reg(input logic [11:0] addr, input logic [31:0] data,
                             input int hold, output logic [1:0] resp);
        int unsigned waited;
        @(negedge clk);
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hF;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        waited = 0;
        while (!(axil_resp.awready && axil_resp.wready)) begin
            tick_wait(waited, "awready and wready");
        end
        @(negedge clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        waited = 0;
        while (!axil_resp.bvalid) tick_wait(waited, "bvalid");
        // response has to stay while bready is low
        repeat (hold) begin
            @(negedge clk);
            if (!axil_resp.bvalid) report_failure("bvalid dropped while bready was low");
        end
        resp = axil_resp.bresp;
        axil_req.bready = 1'b1;
        @(negedge clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic read_reg(input logic [11:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] resp);
        int unsigned waited;
        @(negedge clk);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        waited = 0;
        while (!axil_resp.arready) tick_wait(waited, "arready");
        @(negedge clk);
        axil_req.arvalid = 1'b0;
        waited = 0;
        while (!axil_resp.rvalid) tick_wait(waited, "rvalid");
        repeat (hold) begin
            @(negedge clk);
            if (!axil_resp.rvalid) report_failure("rvalid dropped while rready was low");
        end
        data = axil_resp.rdata;
        resp = axil_resp.rresp;
        axil_req.rready = 1'b1;
        @(negedge clk);
        axil_req.rready = 1'b0;
    endtask

    // the eight counters sit at consecutive addresses from REG_PKTS
    task automatic read_stats(output stats_t s);
        logic [11:0] addr;
        logic [31:0] data;
        logic [1:0]  resp;
        for (int k = 0; k < 8; k++) begin
            addr = REG_PKTS + 12'(4 * k);
            read_reg(addr, 0, data, resp);
            check_resp(reg_name(addr), resp, RESP_OKAY);
            s[255 - 32 * k -: 32] = data;
        end
    endtask

    task automatic compare_counters(input stats_t got, input stats_t exp, input int count);
        logic [11:0] addr;
        for (int k = 0; k < count; k++) begin
            addr = REG_PKTS + 12'(4 * k);
            check_stat(reg_name(addr), got[255 - 32 * k -: 32], exp[255 - 32 * k -: 32]);
        end
    endtask

    initial begin
        stats_t      got;
        stats_t      held;
        logic [31:0] data;
        logic [1:0]  resp;
        void'($urandom(96044));
        resetn      = 1'b0;
        gmii        = '0;
        axil_req    = '0;
        expected    = '0;
        en_cycles   = '0;
        frame_er_at = -1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        // run clear, nothing is counted
        send_frames(3, 1'b0);
        read_reg(REG_ID, 0, data, resp);
        check_stat("id", data, ID_VALUE);
        check_resp("id", resp, RESP_OKAY);
        read_stats(got);
        compare_counters(got, '0, 8);

        write_reg(REG_CONTROL, 32'h1, 0, resp);
        check_resp("control", resp, RESP_OKAY);
        en_cycles = '0;
        send_frames(20, 1'b1);
        read_stats(got);
        compare_counters(got, expected, 6);

        // busy time from the frozen time counters
        write_reg(REG_CONTROL, 32'h3, 0, resp);
        check_resp("control", resp, RESP_OKAY);
        read_stats(held);
        check_stat("octets_total - octets_idle", held.octets_total - held.octets_idle, en_cycles);
        compare_counters(held, expected, 6);

        send_frames(5, 1'b1);
        read_stats(got);
        compare_counters(got, held, 8);
        write_reg(REG_CONTROL, 32'h1, 0, resp);
        check_resp("control", resp, RESP_OKAY);
        send_frames(1, 1'b1);
        read_stats(got);
        compare_counters(got, expected, 6);

        write_reg(REG_PKTS, 32'h1234_5678, 6, resp);
        check_resp("pkts write", resp, RESP_SLVERR);
        read_reg(12'h040, 6, data, resp);
        check_stat("unmapped", data, '0);
        check_resp("unmapped", resp, RESP_SLVERR);
        read_stats(got);
        compare_counters(got, expected, 6);

        // run low clears, then counting restarts from zero
        write_reg(REG_CONTROL, 32'h0, 0, resp);
        check_resp("control", resp, RESP_OKAY);
        read_stats(got);
        compare_counters(got, '0, 8);
        write_reg(REG_CONTROL, 32'h1, 0, resp);
        check_resp("control", resp, RESP_OKAY);
        expected = '0;
        send_frames(1, 1'b1);
        read_stats(got);
        compare_counters(got, expected, 6);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- vlog.f
ta_pkg.sv
frame_checker.sv
frame_rx_fsm.sv
stats_counters.sv
axil_regs.sv
traffic_analyzer.sv
tb_traffic_analyzer.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_traffic_analyzer -o sim_tb

# a failing run exits non-zero, the grep below decides
output=$(./obj_dir/sim_tb || true)
echo "$output"

if grep -q "ALL TESTS PASSED" <<< "$output"; then
    exit 0
fi
exit 1
